// ==== rtl/core_consts.svh ====
// opcode, ALU, branch and CSR codes; included by the decode and execute RTL
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// major opcodes, instruction bits 6:2
`define OP_LOAD   5'b00000
`define OP_STORE  5'b01000
`define OP_CALRI  5'b00100
`define OP_CALRR  5'b01100
`define OP_BRANCH 5'b11000
`define OP_JAL    5'b11011
`define OP_JALR   5'b11001
`define OP_LUI    5'b01101
`define OP_AUIPC  5'b00101
`define OP_SYS    5'b11100

// alu functions, same order as funct3 of the OP/OP-IMM groups
`define ALU_ADD 3'b000
`define ALU_SHL 3'b001
`define ALU_LTS 3'b010
`define ALU_LTU 3'b011
`define ALU_XOR 3'b100
`define ALU_SHR 3'b101
`define ALU_OR  3'b110
`define ALU_AND 3'b111

`define BR_BEQ  3'b000
`define BR_BNE  3'b001
`define BR_BLT  3'b100
`define BR_BGE  3'b101
`define BR_BLTU 3'b110
`define BR_BGEU 3'b111

// funct3 of the SYSTEM csr forms, 3'b000 is ecall/mret
`define CSRF_RW  3'b001
`define CSRF_RS  3'b010
`define CSRF_RC  3'b011
`define CSRF_RWI 3'b101
`define CSRF_RSI 3'b110
`define CSRF_RCI 3'b111

`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

`define CAUSE_ECALL_M 32'd11 // environment call from M-mode

`endif

// ==== rtl/core_pkg.sv ====
// shared instruction views and the packets passed between decode, issue and execute
`default_nettype none

package core_pkg;

  // one 32-bit word seen through each RV32I format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_u;

  typedef struct packed {
    inst_u       inst;
    logic [31:0] pc;
  } fetch_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  opcode;
    logic [2:0]  funct;
    logic [4:0]  rd;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm;
    logic [11:0] csr_addr;
    logic [31:0] csr;      // old value of the addressed csr
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [2:0]  alu_funct;
    logic        alu_funcs; // sub / sra / and-not
  } dec_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wdata;
    logic        redirect;
    logic [31:0] target;
    logic        illegal;
  } retire_t;

  typedef struct packed {
    logic        we;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic        trap;
    logic [31:0] trap_pc;
    logic        mret;
  } csr_wr_t;

endpackage

`default_nettype wire

// ==== rtl/alu.sv ====
// eight-function integer alu, funcs picks sub, arithmetic shift or and-not
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module alu (
  input  wire [31:0]  a,
  input  wire [31:0]  b,
  input  wire [2:0]   funct,
  input  wire         funcs,
  output logic [31:0] y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (funct)
      `ALU_ADD: y = funcs ? a - b : a + b;
      `ALU_SHL: y = a << shamt;
      `ALU_LTS: y = {31'b0, $signed(a) < $signed(b)};
      `ALU_LTU: y = {31'b0, a < b};
      `ALU_XOR: y = a ^ b;
      `ALU_SHR: y = funcs ? 32'($signed(a) >>> shamt) : a >> shamt;
      `ALU_OR:  y = a | b;
      `ALU_AND: y = funcs ? a & ~b : a & b; // csr clear
      default:  y = 32'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/gpr_file.sv ====
// 32x32 integer register file, two combinational reads with write-through
`default_nettype none
`timescale 1ns/1ps

module gpr_file (
  input  wire        clk,
  input  wire        rst_n,
  input  wire [4:0]  raddr1,
  input  wire [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  wire        we,
  input  wire [4:0]  waddr,
  input  wire [31:0] wdata
);

  logic [31:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 1; k < 32; k++)
        regs[k] <= 32'b0;
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // retiring write is visible to the decode in the same cycle
  always_comb begin
    if (raddr1 == 5'd0)
      rdata1 = 32'b0;
    else if (we && waddr == raddr1)
      rdata1 = wdata;
    else
      rdata1 = regs[raddr1];
    if (raddr2 == 5'd0)
      rdata2 = 32'b0;
    else if (we && waddr == raddr2)
      rdata2 = wdata;
    else
      rdata2 = regs[raddr2];
  end

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
// machine-mode csrs with trap entry and mret; reads see the pending update
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module csr_file (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire [11:0]             raddr,
  output logic [31:0]            rdata,
  input  wire core_pkg::csr_wr_t wr
);

  logic        mie_q, mpie_q, mie_n, mpie_n;
  logic [31:0] mtvec_q, mepc_q, mcause_q, mscratch_q;
  logic [31:0] mtvec_n, mepc_n, mcause_n, mscratch_n;

  always_comb begin
    mie_n      = mie_q;
    mpie_n     = mpie_q;
    mtvec_n    = mtvec_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;
    mscratch_n = mscratch_q;
    if (wr.we) begin
      case (wr.addr)
        `CSR_MSTATUS: begin
          mie_n  = wr.wdata[3];
          mpie_n = wr.wdata[7];
        end
        `CSR_MTVEC:    mtvec_n    = wr.wdata;
        `CSR_MEPC:     mepc_n     = wr.wdata;
        `CSR_MCAUSE:   mcause_n   = wr.wdata;
        `CSR_MSCRATCH: mscratch_n = wr.wdata;
        default: ;     // unknown address, write dropped
      endcase
    end
    if (wr.trap) begin
      mepc_n   = wr.trap_pc;
      mcause_n = `CAUSE_ECALL_M;
      mpie_n   = mie_q;
      mie_n    = 1'b0;
    end
    if (wr.mret) begin
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mtvec_q    <= 32'b0;
      mepc_q     <= 32'b0;
      mcause_q   <= 32'b0;
      mscratch_q <= 32'b0;
    end else begin
      mie_q      <= mie_n;
      mpie_q     <= mpie_n;
      mtvec_q    <= mtvec_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
      mscratch_q <= mscratch_n;
    end
  end

  // read from next state, covers write, trap and mret bypass
  always_comb begin
    case (raddr)
      `CSR_MSTATUS:  rdata = {19'b0, 2'b11, 3'b0, mpie_n, 3'b0, mie_n, 3'b0}; // mpp fixed to M
      `CSR_MTVEC:    rdata = mtvec_n;
      `CSR_MEPC:     rdata = mepc_n;
      `CSR_MCAUSE:   rdata = mcause_n;
      `CSR_MSCRATCH: rdata = mscratch_n;
      default:       rdata = 32'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/idu.sv ====
// combinational RV32I decoder; reads registers and csr, builds the packet for issue
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module idu (
  input  wire core_pkg::fetch_t item,
  output logic [4:0]            gpr_raddr1,
  output logic [4:0]            gpr_raddr2,
  input  wire [31:0]            gpr_rdata1,
  input  wire [31:0]            gpr_rdata2,
  output logic [11:0]           csr_raddr,
  input  wire [31:0]            csr_rdata,
  output core_pkg::dec_t        dec
);

  core_pkg::inst_u iw;
  logic [4:0]      opcode;
  logic [2:0]      funct;
  logic [31:0]     imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [31:0]     imm, zimm;
  logic [31:0]     alu_a, alu_b;
  logic [2:0]      alu_funct;
  logic            alu_funcs;

  assign iw     = item.inst;
  assign opcode = iw.r.opcode[6:2];
  assign funct  = iw.r.funct3;

  assign gpr_raddr1 = iw.r.rs1;
  assign gpr_raddr2 = iw.r.rs2;

  assign imm_i = {{20{iw.i.imm11_0[11]}}, iw.i.imm11_0};
  assign imm_s = {{20{iw.s.imm11_5[6]}}, iw.s.imm11_5, iw.s.imm4_0};
  assign imm_b = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
  assign imm_u = {iw.u.imm31_12, 12'b0};
  assign imm_j = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11, iw.j.imm10_1, 1'b0};
  assign zimm  = {27'b0, iw.r.rs1};

  always_comb begin
    case (opcode)
      `OP_CALRI, `OP_LOAD, `OP_JALR, `OP_SYS: imm = imm_i;
      `OP_STORE:                              imm = imm_s;
      `OP_BRANCH:                             imm = imm_b;
      `OP_LUI, `OP_AUIPC:                     imm = imm_u;
      `OP_JAL:                                imm = imm_j;
      default:                                imm = 32'b0; // register-register
    endcase
  end

  // funct3 zero: ecall reads the trap vector, mret the return pc
  always_comb begin
    if (funct != 3'b000)
      csr_raddr = iw.i.imm11_0;
    else if (iw.i.imm11_0 == 12'b0)
      csr_raddr = `CSR_MTVEC;
    else
      csr_raddr = `CSR_MEPC;
  end

  always_comb begin
    case (opcode)
      `OP_LOAD, `OP_STORE, `OP_CALRI, `OP_CALRR, `OP_BRANCH: alu_a = gpr_rdata1;
      `OP_AUIPC, `OP_JAL, `OP_JALR:                          alu_a = item.pc;
      `OP_LUI:                                               alu_a = 32'b0;
      `OP_SYS: begin
        case (funct)
          3'b000:              alu_a = item.pc; // ecall passes its pc through
          `CSRF_RW, `CSRF_RWI: alu_a = 32'b0;
          default:             alu_a = csr_rdata;
        endcase
      end
      default: alu_a = 32'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      `OP_CALRR, `OP_BRANCH:                                 alu_b = gpr_rdata2;
      `OP_LUI, `OP_AUIPC, `OP_LOAD, `OP_STORE, `OP_CALRI:    alu_b = imm;
      `OP_SYS:  alu_b = funct[2] ? zimm : gpr_rdata1; // rs1 is x0 for ecall
      default:  alu_b = 32'd4;                        // jal/jalr link value
    endcase
  end

  always_comb begin
    case (opcode)
      `OP_CALRI, `OP_CALRR: alu_funct = funct;
      `OP_BRANCH: begin
        case (funct)
          `BR_BLT, `BR_BGE:   alu_funct = `ALU_LTS;
          `BR_BLTU, `BR_BGEU: alu_funct = `ALU_LTU;
          default:            alu_funct = `ALU_XOR; // eq/ne test the xor
        endcase
      end
      `OP_SYS: begin
        case (funct)
          `CSRF_RS, `CSRF_RSI: alu_funct = `ALU_OR;
          `CSRF_RC, `CSRF_RCI: alu_funct = `ALU_AND;
          default:             alu_funct = `ALU_XOR;
        endcase
      end
      default: alu_funct = `ALU_ADD;
    endcase
  end

  // bit 30 selects sub/sra; csr clear needs and-not
  assign alu_funcs = (iw.r.funct7[5] & ((opcode == `OP_CALRR) |
                     ((opcode == `OP_CALRI) & (funct == `ALU_SHR)))) |
                     ((opcode == `OP_SYS) & funct[1] & funct[0]);

  always_comb begin
    dec.pc        = item.pc;
    dec.opcode    = opcode;
    dec.funct     = funct;
    dec.rd        = iw.r.rd;
    dec.src1      = gpr_rdata1;
    dec.src2      = gpr_rdata2;
    dec.imm       = imm;
    dec.csr_addr  = csr_raddr;
    dec.csr       = csr_rdata;
    dec.alu_a     = alu_a;
    dec.alu_b     = alu_b;
    dec.alu_funct = alu_funct;
    dec.alu_funcs = alu_funcs;
  end

endmodule

`default_nettype wire

// ==== rtl/exu.sv ====
// execute stage logic for writeback, branch and jump resolution and csr updates, used by the top
`default_nettype none
`timescale 1ns/1ps
`include "core_consts.svh"

module exu (
  input  wire core_pkg::dec_t issued,
  input  wire [31:0]          alu_y,
  output core_pkg::retire_t   rec,
  output core_pkg::csr_wr_t   csr_upd
);

  logic csr_op, ecall, mret_op, wr_rd, taken;

  assign csr_op  = (issued.opcode == `OP_SYS) & (issued.funct[1:0] != 2'b00);
  assign ecall   = (issued.opcode == `OP_SYS) & (issued.funct == 3'b000) &
                   (issued.csr_addr == `CSR_MTVEC);
  assign mret_op = (issued.opcode == `OP_SYS) & (issued.funct == 3'b000) &
                   (issued.csr_addr == `CSR_MEPC);

  always_comb begin
    rec.pc       = issued.pc;
    rec.rd       = issued.rd;
    rec.wdata    = alu_y;
    rec.redirect = 1'b0;
    rec.target   = issued.pc + issued.imm;
    rec.illegal  = 1'b0;
    wr_rd        = 1'b0;
    taken        = 1'b0;
    case (issued.opcode)
      `OP_CALRI, `OP_CALRR, `OP_LUI, `OP_AUIPC: wr_rd = 1'b1;
      `OP_BRANCH: begin
        case (issued.funct)
          `BR_BEQ:           taken = (alu_y == 32'b0);
          `BR_BNE:           taken = (alu_y != 32'b0);
          `BR_BLT, `BR_BLTU: taken = alu_y[0];
          `BR_BGE, `BR_BGEU: taken = ~alu_y[0];
          default:           rec.illegal = 1'b1;
        endcase
        rec.redirect = taken;
      end
      `OP_JAL: begin
        wr_rd        = 1'b1; // alu gives pc+4
        rec.redirect = 1'b1;
      end
      `OP_JALR: begin
        wr_rd        = 1'b1;
        rec.redirect = 1'b1;
        rec.target   = (issued.src1 + issued.imm) & ~32'd1;
      end
      `OP_SYS: begin
        if (csr_op) begin
          wr_rd     = 1'b1;
          rec.wdata = issued.csr; // old value
        end else if (ecall || mret_op) begin
          rec.redirect = 1'b1;
          rec.target   = issued.csr; // mtvec or mepc
        end else begin
          rec.illegal = 1'b1;
        end
      end
      default: rec.illegal = 1'b1; // loads, stores, unknown
    endcase
    rec.we = wr_rd & (issued.rd != 5'd0);
  end

  always_comb begin
    csr_upd.we      = csr_op;
    csr_upd.addr    = issued.csr_addr;
    csr_upd.wdata   = alu_y;
    csr_upd.trap    = ecall;
    csr_upd.trap_pc = alu_y; // pc passed through the alu
    csr_upd.mret    = mret_op;
  end

endmodule

`default_nettype wire

// ==== rtl/issue_ctrl.sv ====
// one-entry issue register with both handshakes, write qualification and wrong-path drop
`default_nettype none
`timescale 1ns/1ps

module issue_ctrl (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    in_valid,
  output logic                   in_ready,
  input  wire core_pkg::fetch_t  in_item,
  input  wire core_pkg::dec_t    dec_in,
  output core_pkg::dec_t         issued,
  input  wire core_pkg::retire_t rec_in,
  input  wire core_pkg::csr_wr_t csr_upd,
  output logic                   ret_valid,
  input  wire                    ret_ready,
  output core_pkg::retire_t      ret_rec,
  output logic                   gpr_we,
  output core_pkg::csr_wr_t      csr_wr
);

  logic           vld_q, drop_q;
  logic [31:0]    await_q;    // redirect target still to be seen
  core_pkg::dec_t issue_q;
  logic           ret_fire, in_fire, kill, take;

  assign ret_fire = vld_q & ret_ready;
  assign in_ready = ~vld_q | ret_fire; // stays high while dropping, register is empty
  assign in_fire  = in_valid & in_ready;
  assign kill     = ret_fire & rec_in.redirect;
  assign take     = in_fire & ~kill & (~drop_q | (in_item.pc == await_q));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      vld_q <= 1'b0;
    else if (take)
      vld_q <= 1'b1;
    else if (ret_fire)
      vld_q <= 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_q  <= 1'b0;
      await_q <= 32'b0;
    end else if (kill) begin
      drop_q  <= 1'b1;
      await_q <= rec_in.target;
    end else if (take) begin
      drop_q  <= 1'b0; // target reached
    end
  end

  always_ff @(posedge clk) begin
    if (take)
      issue_q <= dec_in;
  end

  assign issued    = issue_q;
  assign ret_valid = vld_q;
  assign ret_rec   = rec_in;
  assign gpr_we    = ret_fire & rec_in.we;

  // side effects only on the retire edge
  always_comb begin
    csr_wr      = csr_upd;
    csr_wr.we   = csr_upd.we & ret_fire;
    csr_wr.trap = csr_upd.trap & ret_fire;
    csr_wr.mret = csr_upd.mret & ret_fire;
  end

endmodule

`default_nettype wire

// ==== rtl/core_exec_top.sv ====
// decode/execute slice top level, wires issue control to the datapath blocks
`default_nettype none
`timescale 1ns/1ps

module core_exec_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   in_valid,
  output logic                  in_ready,
  input  wire core_pkg::fetch_t in_item,
  output logic                  ret_valid,
  input  wire                   ret_ready,
  output core_pkg::retire_t     ret_rec
);

  core_pkg::dec_t    dec, issued;
  core_pkg::retire_t rec;
  core_pkg::csr_wr_t csr_upd, csr_wr;
  logic [4:0]        gpr_raddr1, gpr_raddr2;
  logic [31:0]       gpr_rdata1, gpr_rdata2;
  logic [11:0]       csr_raddr;
  logic [31:0]       csr_rdata, alu_y;
  logic              gpr_we;

  issue_ctrl u_issue (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_item  (in_item),
    .dec_in   (dec),
    .issued   (issued),
    .rec_in   (rec),
    .csr_upd  (csr_upd),
    .ret_valid(ret_valid),
    .ret_ready(ret_ready),
    .ret_rec  (ret_rec),
    .gpr_we   (gpr_we),
    .csr_wr   (csr_wr)
  );

  idu u_idu (
    .item      (in_item),
    .gpr_raddr1(gpr_raddr1),
    .gpr_raddr2(gpr_raddr2),
    .gpr_rdata1(gpr_rdata1),
    .gpr_rdata2(gpr_rdata2),
    .csr_raddr (csr_raddr),
    .csr_rdata (csr_rdata),
    .dec       (dec)
  );

  gpr_file u_gpr (
    .clk   (clk),
    .rst_n (rst_n),
    .raddr1(gpr_raddr1),
    .raddr2(gpr_raddr2),
    .rdata1(gpr_rdata1),
    .rdata2(gpr_rdata2),
    .we    (gpr_we),
    .waddr (ret_rec.rd),
    .wdata (ret_rec.wdata)
  );

  csr_file u_csr (
    .clk  (clk),
    .rst_n(rst_n),
    .raddr(csr_raddr),
    .rdata(csr_rdata),
    .wr   (csr_wr)
  );

  alu u_alu (
    .a    (issued.alu_a),
    .b    (issued.alu_b),
    .funct(issued.alu_funct),
    .funcs(issued.alu_funcs),
    .y    (alu_y)
  );

  exu u_exu (
    .issued (issued),
    .alu_y  (alu_y),
    .rec    (rec),
    .csr_upd(csr_upd)
  );

endmodule

`default_nettype wire

// ==== test/tb_core_exec.sv ====
// testbench for the decode/execute slice; plays the data file and checks every retire record
`default_nettype none
`timescale 1ns/1ps

module tb_core_exec;

  localparam int COLS       = 7;   // words per record in the data file
  localparam int MAX_REC    = 128;
  localparam int TIMEOUT    = 200; // cycles per handshake wait
  localparam int MAX_CYCLES = 20000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  core_pkg::fetch_t  in_item;
  logic              ret_valid;
  logic              ret_ready;
  core_pkg::retire_t ret_rec;

  logic [31:0] tdata [0:MAX_REC*COLS-1];
  int          nrec;
  integer      seed;
  int          errors;
  int          checked;
  int          grp_cnt [0:7];
  int          grp_err [0:7];
  logic        aborted;     // timeout or unusable data file
  logic        checks_done;

  core_exec_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_item  (in_item),
    .ret_valid(ret_valid),
    .ret_ready(ret_ready),
    .ret_rec  (ret_rec)
  );

  always #4 clk = ~clk;

  function automatic int rec_group(input int r);
    return int'(tdata[r*COLS][7:4]);
  endfunction

  function automatic logic tag_ok(input logic [31:0] tag);
    return (tag[31:8] == 24'b0) && (tag[7:4] >= 4'd1) && (tag[7:4] <= 4'd6) &&
           (tag[3:1] == 3'b0);
  endfunction

  function automatic int next_expected(input int from);
    int i;
    i = from;
    while (i < nrec && tdata[i*COLS][0])
      i++; // skip wrong-path entries
    return i;
  endfunction

  function automatic logic wrong_path_pc(input logic [31:0] pc);
    for (int i = 0; i < nrec; i++) begin
      if (tdata[i*COLS][0] && tdata[i*COLS+2] == pc)
        return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic string group_name(input int g);
    case (g)
      1:       return "arithmetic and immediates";
      2:       return "back-to-back dependence";
      3:       return "branches and jumps";
      4:       return "csr read-modify-write";
      5:       return "trap entry and return";
      6:       return "out-of-scope opcodes";
      default: return "unknown group";
    endcase
  endfunction

  task automatic load_records();
    for (int k = 0; k < MAX_REC*COLS; k++)
      tdata[k] = 32'hdead0000 | k; // no valid tag anywhere past the file
    $readmemh("test/core_testdata.hex", tdata);
    nrec = 0;
    while (nrec < MAX_REC && tag_ok(tdata[nrec*COLS]))
      nrec++;
  endtask

  task automatic fail_check(input int r, input string msg);
    $display("ERR %0t: entry %0d: %s", $time, r, msg);
    errors++;
    grp_err[rec_group(r)]++;
  endtask

  task automatic compare_record(input int r);
    logic [31:0] ctl;
    logic [31:0] exp_pc;
    ctl    = tdata[r*COLS+3];
    exp_pc = tdata[r*COLS+2];
    checked++;
    grp_cnt[rec_group(r)]++;
    if (ret_rec.pc != exp_pc) begin
      if (wrong_path_pc(ret_rec.pc))
        fail_check(r, $sformatf("wrong-path pc %h retired, expected pc %h", ret_rec.pc, exp_pc));
      else
        fail_check(r, $sformatf("pc %h, expected %h", ret_rec.pc, exp_pc));
    end
    if (ret_rec.we != ctl[2])
      fail_check(r, $sformatf("we %b, expected %b", ret_rec.we, ctl[2]));
    if (ret_rec.redirect != ctl[1])
      fail_check(r, $sformatf("redirect %b, expected %b", ret_rec.redirect, ctl[1]));
    if (ret_rec.illegal != ctl[0])
      fail_check(r, $sformatf("illegal %b, expected %b", ret_rec.illegal, ctl[0]));
    if (ctl[2] && ret_rec.rd != tdata[r*COLS+4][4:0])
      fail_check(r, $sformatf("rd %0d, expected %0d", ret_rec.rd, tdata[r*COLS+4][4:0]));
    if (ctl[2] && ret_rec.wdata != tdata[r*COLS+5])
      fail_check(r, $sformatf("wdata %h, expected %h", ret_rec.wdata, tdata[r*COLS+5]));
    if (ctl[1] && ret_rec.target != tdata[r*COLS+6])
      fail_check(r, $sformatf("target %h, expected %h", ret_rec.target, tdata[r*COLS+6]));
  endtask

  // one item per record, held until accepted
  task automatic drive_items();
    int cnt;
    for (int r = 0; r < nrec && !aborted; r++) begin
      @(negedge clk);
      in_valid     = 1'b1;
      in_item.inst = tdata[r*COLS+1];
      in_item.pc   = tdata[r*COLS+2];
      cnt = 0;
      @(posedge clk);
      while (!in_ready && cnt < TIMEOUT && !aborted) begin
        cnt++;
        @(posedge clk);
      end
      if (!in_ready && !aborted) begin
        $display("timeout: entry %0d was not accepted within %0d cycles", r, TIMEOUT);
        aborted = 1'b1;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic check_retires();
    int idle;
    int r;
    int nxt;
    r = next_expected(0);
    while (r < nrec && !aborted) begin
      idle = 0;
      @(posedge clk);
      while (!(ret_valid && ret_ready) && idle < TIMEOUT) begin
        idle++;
        @(posedge clk);
      end
      if (ret_valid && ret_ready) begin
        compare_record(r);
        nxt = next_expected(r + 1);
        if (nxt >= nrec || rec_group(nxt) != rec_group(r))
          $display("group %0d (%s): %0d records, %0d errors", rec_group(r),
                   group_name(rec_group(r)), grp_cnt[rec_group(r)], grp_err[rec_group(r)]);
        r = nxt;
      end else begin
        $display("timeout: no retire record for entry %0d within %0d cycles", r, TIMEOUT);
        aborted = 1'b1;
      end
    end
    checks_done = 1'b1;
  endtask

  // random back-pressure, about one cycle in four
  task automatic drive_stalls();
    int cyc;
    cyc = 0;
    while (!checks_done && cyc < MAX_CYCLES) begin
      @(negedge clk);
      ret_ready = (($random(seed) & 3) != 0);
      cyc++;
    end
    @(negedge clk);
    ret_ready = 1'b1;
  endtask

  // nothing may retire after the last expected record
  task automatic check_idle();
    repeat (8) begin
      @(posedge clk);
      if (ret_valid) begin
        $display("ERR %0t: record at pc %h retired after the last entry", $time, ret_rec.pc);
        errors++;
      end
    end
  endtask

  initial begin
    seed        = 32'hf1bf;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_item     = '0;
    ret_ready   = 1'b0;
    errors      = 0;
    checked     = 0;
    aborted     = 1'b0;
    checks_done = 1'b0;
    for (int g = 0; g < 8; g++) begin
      grp_cnt[g] = 0;
      grp_err[g] = 0;
    end
    load_records();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (nrec == 0) begin
      $display("no usable records found in test/core_testdata.hex");
      aborted = 1'b1;
    end else begin
      fork
        drive_items();
        check_retires();
        drive_stalls();
      join
    end
    if (!aborted)
      check_idle();
    $display("%0d records checked, %0d errors", checked, errors);
    if (errors == 0 && !aborted)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/alu.sv
rtl/gpr_file.sv
rtl/csr_file.sv
rtl/idu.sv
rtl/exu.sv
rtl/issue_ctrl.sv
rtl/core_exec_top.sv
test/tb_core_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the decode/execute testbench with Verilator, run it and grade the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_core_exec \
  --Mdir "$BUILD_DIR" -o tb_core_exec
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_core_exec" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/core_testdata.hex ====
// tag(group<<4 | wrong-path) inst pc ctl(we,redirect,illegal) rd wdata target
// rd and wdata count only when we is set, target only when redirect is set
10 00500093 00000100 4 01 00000005 00000000
10 ffd00113 00000104 4 02 fffffffd 00000000
10 002081b3 00000108 4 03 00000002 00000000
10 40208233 0000010c 4 04 00000008 00000000
10 001122b3 00000110 4 05 00000001 00000000
10 00113333 00000114 4 06 00000000 00000000
10 40115393 00000118 4 07 fffffffe 00000000
10 00415413 0000011c 4 08 0fffffff 00000000
10 0ff0c493 00000120 4 09 000000fa 00000000
10 12345537 00000124 4 0a 12345000 00000000
10 00001597 00000128 4 0b 00001128 00000000
10 00309613 0000012c 4 0c 00000028 00000000
10 001176b3 00000130 4 0d 00000005 00000000
20 01000713 00000134 4 0e 00000010 00000000
20 00e707b3 00000138 4 0f 00000020 00000000
20 00e78833 0000013c 4 10 00000030 00000000
20 00178793 00000140 4 0f 00000021 00000000
20 40f808b3 00000144 4 11 0000000f 00000000
20 00700013 00000148 0 00 00000000 00000000
20 01100933 0000014c 4 12 0000000f 00000000
30 00108863 00000150 2 00 00000000 00000160
31 06300093 00000154 0 00 00000000 00000000
30 00208463 00000160 0 00 00000000 00000000
30 fe114ce3 00000164 2 00 00000000 0000015c
31 00100113 00000168 0 00 00000000 00000000
30 02117063 0000015c 2 00 00000000 0000017c
31 00100193 00000160 0 00 00000000 00000000
30 040009ef 0000017c 6 13 00000180 000001bc
31 00100213 00000180 0 00 00000000 00000000
30 20288a67 000001bc 6 14 000001c0 00000210
31 00100293 000001c0 0 00 00000000 00000000
30 01498ab3 00000210 4 15 00000340 00000000
40 34009b73 00000214 4 16 00000000 00000000
40 3404abf3 00000218 4 17 00000005 00000000
40 3400bc73 0000021c 4 18 000000ff 00000000
40 340ddcf3 00000220 4 19 000000fa 00000000
40 34026d73 00000224 4 1a 0000001b 00000000
40 3401fdf3 00000228 4 1b 0000001f 00000000
40 34002e73 0000022c 4 1c 0000001c 00000000
40 40000e93 00000230 4 1d 00000400 00000000
40 305e9073 00000234 0 00 00000000 00000000
50 00000073 00000238 2 00 00000000 00000400
51 00100313 0000023c 0 00 00000000 00000000
50 34102f73 00000400 4 1e 00000238 00000000
50 34202ff3 00000404 4 1f 0000000b 00000000
50 004f0f13 00000408 4 1e 0000023c 00000000
50 341f1073 0000040c 0 00 00000000 00000000
50 30200073 00000410 2 00 00000000 0000023c
51 00100393 00000414 0 00 00000000 00000000
50 30002473 0000023c 4 08 00001880 00000000
60 0000a483 00000240 1 00 00000000 00000000
60 00112223 00000244 1 00 00000000 00000000
60 0000007f 00000248 1 00 00000000 00000000
60 001484b3 0000024c 4 09 000000ff 00000000
